// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - decode_pkg.sv
  - reg_file.sv
  - main_control.sv
  - alu_control.sv
  - decode.sv
  - target: simulation
    files:
      - decode_checker.sv
      - decode_tb.sv

// ==== alu_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_control (
    input  wire  [3:0] alu_cmd,
    input  wire  [1:0] func,
    output logic [2:0] alu_op,
    output logic       inv_a,
    output logic       inv_b,
    output logic       cin
);

    always_comb begin
        alu_op = decode_pkg::ALU_ADD;
        inv_a  = 1'b0;
        inv_b  = 1'b0;
        cin    = 1'b0;

        case (alu_cmd)
            decode_pkg::CMD_ADD: alu_op = decode_pkg::ALU_ADD;
            // Immediate minus rs
            decode_pkg::CMD_SUBI: begin
                inv_a = 1'b1;
                cin   = 1'b1;
            end
            // rs minus rt, for the set instructions
            decode_pkg::CMD_CMP: begin
                inv_b = 1'b1;
                cin   = 1'b1;
            end
            decode_pkg::CMD_XOR: alu_op = decode_pkg::ALU_XOR;
            decode_pkg::CMD_ANDN: begin
                alu_op = decode_pkg::ALU_AND;
                inv_b  = 1'b1;
            end
            decode_pkg::CMD_OR:  alu_op = decode_pkg::ALU_OR;
            decode_pkg::CMD_ROL: alu_op = decode_pkg::ALU_ROL;
            decode_pkg::CMD_SLL: alu_op = decode_pkg::ALU_SLL;
            decode_pkg::CMD_ROR: alu_op = decode_pkg::ALU_ROR;
            decode_pkg::CMD_SRL: alu_op = decode_pkg::ALU_SRL;
            decode_pkg::CMD_RR_ARITH: begin
                case (func)
                    2'b00: alu_op = decode_pkg::ALU_ADD;
                    2'b01: begin
                        inv_a = 1'b1;
                        cin   = 1'b1;
                    end
                    2'b10: alu_op = decode_pkg::ALU_XOR;
                    default: begin
                        alu_op = decode_pkg::ALU_AND;
                        inv_b  = 1'b1;
                    end
                endcase
            end
            // Shift codes line up with func
            decode_pkg::CMD_RR_SHIFT: alu_op = {1'b0, func};
            default: alu_op = decode_pkg::ALU_ADD;
        endcase
    end

endmodule

`default_nettype wire

// ==== decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode (
    input  wire         clk,
    input  wire         rst_n,
    input  wire  [15:0] instruction,
    input  wire  [15:0] mem_write_back,
    output logic [1:0]  alu_src_a,
    output logic [1:0]  alu_src_b,
    output logic        sign_alu,
    output logic [1:0]  set_select,
    output logic        alu_res_sel,
    output logic [1:0]  mem_to_reg,
    output logic [1:0]  pc_dec,
    output logic        branch,
    output logic        branch_eqz,
    output logic        branch_gtz,
    output logic        branch_ltz,
    output logic        mem_read,
    output logic        mem_write,
    output logic        control_err,
    output logic        halt,
    output logic        createdump,
    output logic [2:0]  alu_op,
    output logic        inv_a,
    output logic        inv_b,
    output logic        cin,
    output logic [15:0] reg1_data,
    output logic [15:0] reg2_data,
    output logic [15:0] sign_ext_imm
);

    decode_pkg::instr_t instr;
    logic               reg_write;
    logic [1:0]         dst_sel;
    logic [1:0]         imm_sel;
    logic [3:0]         alu_cmd;
    logic [2:0]         write_sel;

    assign instr = instruction;

    main_control u_main_control (
        .opcode      (instr.r_fmt.opcode),
        .reg_write   (reg_write),
        .dst_sel     (dst_sel),
        .imm_sel     (imm_sel),
        .alu_cmd     (alu_cmd),
        .alu_src_a   (alu_src_a),
        .alu_src_b   (alu_src_b),
        .sign_alu    (sign_alu),
        .set_select  (set_select),
        .alu_res_sel (alu_res_sel),
        .mem_to_reg  (mem_to_reg),
        .pc_dec      (pc_dec),
        .branch      (branch),
        .branch_eqz  (branch_eqz),
        .branch_gtz  (branch_gtz),
        .branch_ltz  (branch_ltz),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .control_err (control_err),
        .halt        (halt),
        .createdump  (createdump)
    );

    alu_control u_alu_control (
        .alu_cmd (alu_cmd),
        .func    (instr.r_fmt.func),
        .alu_op  (alu_op),
        .inv_a   (inv_a),
        .inv_b   (inv_b),
        .cin     (cin)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .read1_sel  (instr.r_fmt.rs),
        .read2_sel  (instr.r_fmt.rt),
        .write_sel  (write_sel),
        .write_data (mem_write_back),
        .write      (reg_write),
        .read1_data (reg1_data),
        .read2_data (reg2_data)
    );

    always_comb begin
        case (dst_sel)
            decode_pkg::DST_RS: write_sel = instr.r_fmt.rs;
            decode_pkg::DST_RD: write_sel = instr.r_fmt.rd;
            decode_pkg::DST_R7: write_sel = 3'd7;
            default:            write_sel = instr.i1_fmt.rd;
        endcase
    end

    always_comb begin
        case (imm_sel)
            decode_pkg::IMM_SEXT5: sign_ext_imm = {{11{instr.i1_fmt.imm5[4]}}, instr.i1_fmt.imm5};
            decode_pkg::IMM_SEXT8: sign_ext_imm = {{8{instr.i2_fmt.imm8[7]}}, instr.i2_fmt.imm8};
            decode_pkg::IMM_ZEXT5: sign_ext_imm = {11'b0, instr.i1_fmt.imm5};
            default:               sign_ext_imm = {8'b0, instr.i2_fmt.imm8};
        endcase
    end

endmodule

`default_nettype wire

// ==== decode_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_checker (
    input  wire         clk,
    input  wire         rst_n,
    input  wire  [15:0] instruction,
    input  wire  [15:0] mem_write_back,
    input  wire  [1:0]  alu_src_a,
    input  wire  [1:0]  alu_src_b,
    input  wire         sign_alu,
    input  wire  [1:0]  set_select,
    input  wire         alu_res_sel,
    input  wire  [1:0]  mem_to_reg,
    input  wire  [1:0]  pc_dec,
    input  wire         branch,
    input  wire         branch_eqz,
    input  wire         branch_gtz,
    input  wire         branch_ltz,
    input  wire         mem_read,
    input  wire         mem_write,
    input  wire         control_err,
    input  wire         halt,
    input  wire         createdump,
    input  wire  [2:0]  alu_op,
    input  wire         inv_a,
    input  wire         inv_b,
    input  wire         cin,
    input  wire  [15:0] reg1_data,
    input  wire  [15:0] reg2_data,
    input  wire  [15:0] sign_ext_imm,
    output logic [31:0] samples,
    output logic [31:0] checks,
    output logic [31:0] errors
);

    logic        exp_rw;
    logic [2:0]  exp_dst;
    logic [15:0] exp_imm;
    logic [1:0]  exp_src_a;
    logic [1:0]  exp_src_b;
    logic        exp_sign;
    logic [1:0]  exp_set;
    logic        exp_res;
    logic [1:0]  exp_wb;
    logic [1:0]  exp_pc;
    logic        exp_br;
    logic        exp_beqz;
    logic        exp_bgtz;
    logic        exp_bltz;
    logic        exp_mrd;
    logic        exp_mwr;
    logic        exp_err;
    logic        exp_halt;
    logic [2:0]  exp_op;
    logic        exp_inv_a;
    logic        exp_inv_b;
    logic        exp_cin;

    logic [15:0] shadow [8];
    logic        pend_we;
    logic [2:0]  pend_sel;
    logic [15:0] pend_data;

    function automatic void alu_expect(input logic [2:0] op, input logic ia, input logic ib,
                                       input logic c);
        exp_op    = op;
        exp_inv_a = ia;
        exp_inv_b = ib;
        exp_cin   = c;
    endfunction

    // Expected decode of one instruction word
    function automatic void predict(input logic [15:0] ins);
        logic [4:0] op;
        logic [1:0] func;
        logic [1:0] imm_kind;
        logic [1:0] dst_kind;
        op        = ins[15:11];
        func      = ins[1:0];
        imm_kind  = decode_pkg::IMM_SEXT5;
        dst_kind  = decode_pkg::DST_RS;
        exp_rw    = 1'b0;
        exp_src_a = decode_pkg::SRC_A_RS;
        exp_src_b = decode_pkg::SRC_B_RT;
        exp_sign  = 1'b0;
        exp_set   = decode_pkg::SET_EQ;
        exp_res   = 1'b0;
        exp_wb    = decode_pkg::WB_ALU;
        exp_pc    = decode_pkg::PC_SEQ;
        exp_br    = 1'b0;
        exp_beqz  = 1'b0;
        exp_bgtz  = 1'b0;
        exp_bltz  = 1'b0;
        exp_mrd   = 1'b0;
        exp_mwr   = 1'b0;
        exp_err   = 1'b0;
        exp_halt  = 1'b0;
        alu_expect(decode_pkg::ALU_ADD, 1'b0, 1'b0, 1'b0);
        case (op)
            decode_pkg::OP_HALT: exp_halt = 1'b1;
            decode_pkg::OP_NOP: ;
            decode_pkg::OP_ADDI, decode_pkg::OP_SUBI: begin
                exp_rw    = 1'b1;
                dst_kind  = decode_pkg::DST_RT;
                exp_src_b = decode_pkg::SRC_B_IMM;
                exp_sign  = 1'b1;
                if (op == decode_pkg::OP_SUBI) begin
                    alu_expect(decode_pkg::ALU_ADD, 1'b1, 1'b0, 1'b1);
                end
            end
            decode_pkg::OP_XORI, decode_pkg::OP_ANDNI, decode_pkg::OP_ROLI,
            decode_pkg::OP_SLLI, decode_pkg::OP_RORI, decode_pkg::OP_SRLI: begin
                exp_rw    = 1'b1;
                dst_kind  = decode_pkg::DST_RT;
                imm_kind  = decode_pkg::IMM_ZEXT5;
                exp_src_b = decode_pkg::SRC_B_IMM;
                case (op)
                    decode_pkg::OP_XORI:  alu_expect(decode_pkg::ALU_XOR, 1'b0, 1'b0, 1'b0);
                    decode_pkg::OP_ANDNI: alu_expect(decode_pkg::ALU_AND, 1'b0, 1'b1, 1'b0);
                    decode_pkg::OP_ROLI:  alu_expect(decode_pkg::ALU_ROL, 1'b0, 1'b0, 1'b0);
                    decode_pkg::OP_SLLI:  alu_expect(decode_pkg::ALU_SLL, 1'b0, 1'b0, 1'b0);
                    decode_pkg::OP_RORI:  alu_expect(decode_pkg::ALU_ROR, 1'b0, 1'b0, 1'b0);
                    default:              alu_expect(decode_pkg::ALU_SRL, 1'b0, 1'b0, 1'b0);
                endcase
            end
            decode_pkg::OP_ST: begin
                exp_mwr   = 1'b1;
                exp_src_b = decode_pkg::SRC_B_IMM;
            end
            decode_pkg::OP_LD: begin
                exp_mrd   = 1'b1;
                exp_src_b = decode_pkg::SRC_B_IMM;
                exp_rw    = 1'b1;
                dst_kind  = decode_pkg::DST_RT;
                exp_wb    = decode_pkg::WB_MEM;
            end
            decode_pkg::OP_LBI: begin
                exp_rw    = 1'b1;
                imm_kind  = decode_pkg::IMM_SEXT8;
                exp_src_a = decode_pkg::SRC_A_ZERO;
                exp_src_b = decode_pkg::SRC_B_IMM;
            end
            decode_pkg::OP_SLBI: begin
                exp_rw    = 1'b1;
                imm_kind  = decode_pkg::IMM_ZEXT8;
                exp_src_a = decode_pkg::SRC_A_RS_SHL8;
                exp_src_b = decode_pkg::SRC_B_IMM;
                alu_expect(decode_pkg::ALU_OR, 1'b0, 1'b0, 1'b0);
            end
            decode_pkg::OP_ARITH: begin
                exp_rw   = 1'b1;
                dst_kind = decode_pkg::DST_RD;
                case (func)
                    2'b00:   alu_expect(decode_pkg::ALU_ADD, 1'b0, 1'b0, 1'b0);
                    2'b01:   alu_expect(decode_pkg::ALU_ADD, 1'b1, 1'b0, 1'b1);
                    2'b10:   alu_expect(decode_pkg::ALU_XOR, 1'b0, 1'b0, 1'b0);
                    default: alu_expect(decode_pkg::ALU_AND, 1'b0, 1'b1, 1'b0);
                endcase
            end
            decode_pkg::OP_SHIFT: begin
                exp_rw   = 1'b1;
                dst_kind = decode_pkg::DST_RD;
                case (func)
                    2'b00:   alu_expect(decode_pkg::ALU_ROL, 1'b0, 1'b0, 1'b0);
                    2'b01:   alu_expect(decode_pkg::ALU_SLL, 1'b0, 1'b0, 1'b0);
                    2'b10:   alu_expect(decode_pkg::ALU_ROR, 1'b0, 1'b0, 1'b0);
                    default: alu_expect(decode_pkg::ALU_SRL, 1'b0, 1'b0, 1'b0);
                endcase
            end
            decode_pkg::OP_SEQ, decode_pkg::OP_SLT, decode_pkg::OP_SLE: begin
                exp_rw   = 1'b1;
                dst_kind = decode_pkg::DST_RD;
                exp_sign = 1'b1;
                exp_res  = 1'b1;
                exp_wb   = decode_pkg::WB_SET;
                alu_expect(decode_pkg::ALU_ADD, 1'b0, 1'b1, 1'b1);
                if (op == decode_pkg::OP_SLT) begin
                    exp_set = decode_pkg::SET_LT;
                end else if (op == decode_pkg::OP_SLE) begin
                    exp_set = decode_pkg::SET_LE;
                end
            end
            decode_pkg::OP_BEQZ, decode_pkg::OP_BNEZ,
            decode_pkg::OP_BLTZ, decode_pkg::OP_BGEZ: begin
                exp_br    = 1'b1;
                exp_pc    = decode_pkg::PC_BRANCH;
                imm_kind  = decode_pkg::IMM_SEXT8;
                exp_src_b = decode_pkg::SRC_B_ZERO;
                case (op)
                    decode_pkg::OP_BEQZ: exp_beqz = 1'b1;
                    decode_pkg::OP_BNEZ: begin
                        exp_beqz = 1'b1;
                        exp_bltz = 1'b1;
                    end
                    decode_pkg::OP_BLTZ: exp_bltz = 1'b1;
                    default:             exp_bgtz = 1'b1;
                endcase
            end
            decode_pkg::OP_J: exp_pc = decode_pkg::PC_JUMP;
            decode_pkg::OP_JAL: begin
                exp_pc   = decode_pkg::PC_JUMP;
                exp_rw   = 1'b1;
                dst_kind = decode_pkg::DST_R7;
                exp_wb   = decode_pkg::WB_PC2;
            end
            default: exp_err = 1'b1;
        endcase
        case (imm_kind)
            decode_pkg::IMM_SEXT5: exp_imm = {{11{ins[4]}}, ins[4:0]};
            decode_pkg::IMM_SEXT8: exp_imm = {{8{ins[7]}}, ins[7:0]};
            decode_pkg::IMM_ZEXT5: exp_imm = {11'b0, ins[4:0]};
            default:               exp_imm = {8'b0, ins[7:0]};
        endcase
        case (dst_kind)
            decode_pkg::DST_RS: exp_dst = ins[10:8];
            decode_pkg::DST_RD: exp_dst = ins[4:2];
            decode_pkg::DST_R7: exp_dst = 3'd7;
            default:            exp_dst = ins[7:5];
        endcase
    endfunction

    task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
        checks = checks + 1;
        if (act !== exp) begin
            errors = errors + 1;
            $display("[FAIL] %s expected %h actual %h (instruction %h)",
                     name, exp, act, instruction);
        end
    endtask

    task automatic compare_all();
        predict(instruction);
        check_val("alu_src_a", exp_src_a, alu_src_a);
        check_val("alu_src_b", exp_src_b, alu_src_b);
        check_val("sign_alu", exp_sign, sign_alu);
        check_val("set_select", exp_set, set_select);
        check_val("alu_res_sel", exp_res, alu_res_sel);
        check_val("mem_to_reg", exp_wb, mem_to_reg);
        check_val("pc_dec", exp_pc, pc_dec);
        check_val("branch", exp_br, branch);
        check_val("branch_eqz", exp_beqz, branch_eqz);
        check_val("branch_gtz", exp_bgtz, branch_gtz);
        check_val("branch_ltz", exp_bltz, branch_ltz);
        check_val("mem_read", exp_mrd, mem_read);
        check_val("mem_write", exp_mwr, mem_write);
        check_val("control_err", exp_err, control_err);
        check_val("halt", exp_halt, halt);
        check_val("createdump", 16'h0000, createdump);
        check_val("alu_op", exp_op, alu_op);
        check_val("inv_a", exp_inv_a, inv_a);
        check_val("inv_b", exp_inv_b, inv_b);
        check_val("cin", exp_cin, cin);
        check_val("sign_ext_imm", exp_imm, sign_ext_imm);
        check_val("reg1_data", shadow[instruction[10:8]], reg1_data);
        check_val("reg2_data", shadow[instruction[7:5]], reg2_data);
        // Write lands at the coming edge, with the values held until then
        pend_we   = exp_rw && rst_n;
        pend_sel  = exp_dst;
        pend_data = mem_write_back;
        if (rst_n) begin
            samples = samples + 1;
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                shadow[i] <= 16'h0000;
            end
        end else if (pend_we) begin
            shadow[pend_sel] <= pend_data;
        end
    end

    // Sample 1 ns ahead of each rising edge of the 8 ns clock
    initial begin
        samples = 0;
        checks  = 0;
        errors  = 0;
        pend_we = 1'b0;
        forever begin
            @(posedge clk);
            #7;
            compare_all();
        end
    end

endmodule

`default_nettype wire

// ==== decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    // Instruction word, read as R, I1 or I2 format depending on the opcode
    typedef union packed {
        struct packed {
            logic [4:0] opcode;
            logic [2:0] rs;
            logic [2:0] rt;
            logic [2:0] rd;
            logic [1:0] func;
        } r_fmt;
        struct packed {
            logic [4:0] opcode;
            logic [2:0] rs;
            logic [2:0] rd;
            logic [4:0] imm5;
        } i1_fmt;
        struct packed {
            logic [4:0] opcode;
            logic [2:0] rs;
            logic [7:0] imm8;
        } i2_fmt;
    } instr_t;

    // Opcodes
    localparam logic [4:0] OP_HALT  = 5'b00000;
    localparam logic [4:0] OP_NOP   = 5'b00001;
    localparam logic [4:0] OP_J     = 5'b00100;
    localparam logic [4:0] OP_JAL   = 5'b00110;
    localparam logic [4:0] OP_ADDI  = 5'b01000;
    localparam logic [4:0] OP_SUBI  = 5'b01001;
    localparam logic [4:0] OP_XORI  = 5'b01010;
    localparam logic [4:0] OP_ANDNI = 5'b01011;
    localparam logic [4:0] OP_BEQZ  = 5'b01100;
    localparam logic [4:0] OP_BNEZ  = 5'b01101;
    localparam logic [4:0] OP_BLTZ  = 5'b01110;
    localparam logic [4:0] OP_BGEZ  = 5'b01111;
    localparam logic [4:0] OP_ST    = 5'b10000;
    localparam logic [4:0] OP_LD    = 5'b10001;
    localparam logic [4:0] OP_SLBI  = 5'b10010;
    localparam logic [4:0] OP_ROLI  = 5'b10100;
    localparam logic [4:0] OP_SLLI  = 5'b10101;
    localparam logic [4:0] OP_RORI  = 5'b10110;
    localparam logic [4:0] OP_SRLI  = 5'b10111;
    localparam logic [4:0] OP_LBI   = 5'b11000;
    localparam logic [4:0] OP_SHIFT = 5'b11010;
    localparam logic [4:0] OP_ARITH = 5'b11011;
    localparam logic [4:0] OP_SEQ   = 5'b11100;
    localparam logic [4:0] OP_SLT   = 5'b11101;
    localparam logic [4:0] OP_SLE   = 5'b11110;

    // Destination register select
    localparam logic [1:0] DST_RS = 2'd0;
    localparam logic [1:0] DST_RD = 2'd1;
    localparam logic [1:0] DST_R7 = 2'd2;
    localparam logic [1:0] DST_RT = 2'd3;

    // Immediate extension select
    localparam logic [1:0] IMM_SEXT5 = 2'd0;
    localparam logic [1:0] IMM_SEXT8 = 2'd1;
    localparam logic [1:0] IMM_ZEXT5 = 2'd2;
    localparam logic [1:0] IMM_ZEXT8 = 2'd3;

    // Commands from main control to ALU control
    localparam logic [3:0] CMD_ADD      = 4'd0;
    localparam logic [3:0] CMD_SUBI     = 4'd1;
    localparam logic [3:0] CMD_XOR      = 4'd2;
    localparam logic [3:0] CMD_ANDN     = 4'd3;
    localparam logic [3:0] CMD_ROL      = 4'd4;
    localparam logic [3:0] CMD_SLL      = 4'd5;
    localparam logic [3:0] CMD_ROR      = 4'd6;
    localparam logic [3:0] CMD_SRL      = 4'd7;
    localparam logic [3:0] CMD_RR_ARITH = 4'd8;
    localparam logic [3:0] CMD_RR_SHIFT = 4'd9;
    localparam logic [3:0] CMD_CMP      = 4'd10;
    localparam logic [3:0] CMD_OR       = 4'd11;

    // ALU operations
    localparam logic [2:0] ALU_ROL = 3'd0;
    localparam logic [2:0] ALU_SLL = 3'd1;
    localparam logic [2:0] ALU_ROR = 3'd2;
    localparam logic [2:0] ALU_SRL = 3'd3;
    localparam logic [2:0] ALU_ADD = 3'd4;
    localparam logic [2:0] ALU_OR  = 3'd5;
    localparam logic [2:0] ALU_XOR = 3'd6;
    localparam logic [2:0] ALU_AND = 3'd7;

    // Operand sources
    localparam logic [1:0] SRC_A_RS      = 2'd0;
    localparam logic [1:0] SRC_A_RS_SHL8 = 2'd1;
    localparam logic [1:0] SRC_A_ZERO    = 2'd2;
    localparam logic [1:0] SRC_B_RT      = 2'd0;
    localparam logic [1:0] SRC_B_IMM     = 2'd1;
    localparam logic [1:0] SRC_B_ZERO    = 2'd2;

    // Write-back source
    localparam logic [1:0] WB_ALU = 2'd0;
    localparam logic [1:0] WB_MEM = 2'd1;
    localparam logic [1:0] WB_PC2 = 2'd2;
    localparam logic [1:0] WB_SET = 2'd3;

    // Next PC source
    localparam logic [1:0] PC_SEQ    = 2'd0;
    localparam logic [1:0] PC_BRANCH = 2'd1;
    localparam logic [1:0] PC_JUMP   = 2'd2;

    // Set condition
    localparam logic [1:0] SET_EQ = 2'd0;
    localparam logic [1:0] SET_LT = 2'd1;
    localparam logic [1:0] SET_LE = 2'd2;

endpackage

`default_nettype wire

// ==== decode_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_tb;

    logic        clk;
    logic        rst_n;
    logic [15:0] instruction;
    logic [15:0] mem_write_back;
    wire  [1:0]  alu_src_a;
    wire  [1:0]  alu_src_b;
    wire         sign_alu;
    wire  [1:0]  set_select;
    wire         alu_res_sel;
    wire  [1:0]  mem_to_reg;
    wire  [1:0]  pc_dec;
    wire         branch;
    wire         branch_eqz;
    wire         branch_gtz;
    wire         branch_ltz;
    wire         mem_read;
    wire         mem_write;
    wire         control_err;
    wire         halt;
    wire         createdump;
    wire  [2:0]  alu_op;
    wire         inv_a;
    wire         inv_b;
    wire         cin;
    wire  [15:0] reg1_data;
    wire  [15:0] reg2_data;
    wire  [15:0] sign_ext_imm;
    wire  [31:0] samples;
    wire  [31:0] checks;
    wire  [31:0] errors;
    int          timeouts;

    decode dut0 (.*);

    decode_checker chk0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic apply(input logic [15:0] ins, input logic [15:0] wb);
        @(posedge clk);
        #1;
        instruction    = ins;
        mem_write_back = wb;
    endtask

    task automatic wait_samples(input int target, input int limit, input string what);
        int n;
        n = 0;
        while (samples < target && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (samples < target) begin
            $display("Timeout while waiting for %s", what);
            timeouts++;
        end
    endtask

    // Reads every register through both ports without writing
    task automatic read_all();
        logic [31:0] rnd;
        for (int r = 0; r < 8; r++) begin
            rnd = $urandom;
            apply({decode_pkg::OP_NOP, r[2:0], 3'd7 - r[2:0], rnd[4:0]}, rnd[31:16]);
        end
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] wb;
        rst_n          = 1'b0;
        instruction    = {decode_pkg::OP_NOP, 11'h000};
        mem_write_back = 16'h0000;
        timeouts       = 0;
        void'($urandom(32'h5d27e580));
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        wait_samples(1, 10, "the end of reset");
        read_all();
        // All 32 opcodes, legal and illegal, with random fields
        for (int rep = 0; rep < 4; rep++) begin
            for (int op = 0; op < 32; op++) begin
                rnd = $urandom;
                wb  = $urandom;
                apply({op[4:0], rnd[10:0]}, wb[15:0]);
            end
        end
        for (int f = 0; f < 4; f++) begin
            rnd = $urandom;
            wb  = $urandom;
            apply({decode_pkg::OP_ARITH, rnd[10:2], f[1:0]}, wb[15:0]);
            apply({decode_pkg::OP_SHIFT, rnd[26:18], f[1:0]}, wb[31:16]);
        end
        read_all();
        wait_samples(samples + 2, 10, "the last stimulus to be checked");
        $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== main_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module main_control (
    input  wire  [4:0] opcode,
    output logic       reg_write,
    output logic [1:0] dst_sel,
    output logic [1:0] imm_sel,
    output logic [3:0] alu_cmd,
    output logic [1:0] alu_src_a,
    output logic [1:0] alu_src_b,
    output logic       sign_alu,
    output logic [1:0] set_select,
    output logic       alu_res_sel,
    output logic [1:0] mem_to_reg,
    output logic [1:0] pc_dec,
    output logic       branch,
    output logic       branch_eqz,
    output logic       branch_gtz,
    output logic       branch_ltz,
    output logic       mem_read,
    output logic       mem_write,
    output logic       control_err,
    output logic       halt,
    output logic       createdump
);

    always_comb begin
        reg_write   = 1'b0;
        dst_sel     = decode_pkg::DST_RS;
        imm_sel     = decode_pkg::IMM_SEXT5;
        alu_cmd     = decode_pkg::CMD_ADD;
        alu_src_a   = decode_pkg::SRC_A_RS;
        alu_src_b   = decode_pkg::SRC_B_RT;
        sign_alu    = 1'b0;
        set_select  = decode_pkg::SET_EQ;
        alu_res_sel = 1'b0;
        mem_to_reg  = decode_pkg::WB_ALU;
        pc_dec      = decode_pkg::PC_SEQ;
        branch      = 1'b0;
        branch_eqz  = 1'b0;
        branch_gtz  = 1'b0;
        branch_ltz  = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        control_err = 1'b0;
        halt        = 1'b0;

        case (opcode)
            decode_pkg::OP_HALT: halt = 1'b1;
            decode_pkg::OP_NOP: ;
            decode_pkg::OP_ADDI, decode_pkg::OP_SUBI: begin
                reg_write = 1'b1;
                dst_sel   = decode_pkg::DST_RT;
                alu_src_b = decode_pkg::SRC_B_IMM;
                sign_alu  = 1'b1;
                alu_cmd   = (opcode == decode_pkg::OP_ADDI) ? decode_pkg::CMD_ADD
                                                            : decode_pkg::CMD_SUBI;
            end
            decode_pkg::OP_XORI, decode_pkg::OP_ANDNI,
            decode_pkg::OP_ROLI, decode_pkg::OP_SLLI,
            decode_pkg::OP_RORI, decode_pkg::OP_SRLI: begin
                reg_write = 1'b1;
                dst_sel   = decode_pkg::DST_RT;
                imm_sel   = decode_pkg::IMM_ZEXT5;
                alu_src_b = decode_pkg::SRC_B_IMM;
                case (opcode)
                    decode_pkg::OP_XORI:  alu_cmd = decode_pkg::CMD_XOR;
                    decode_pkg::OP_ANDNI: alu_cmd = decode_pkg::CMD_ANDN;
                    decode_pkg::OP_ROLI:  alu_cmd = decode_pkg::CMD_ROL;
                    decode_pkg::OP_SLLI:  alu_cmd = decode_pkg::CMD_SLL;
                    decode_pkg::OP_RORI:  alu_cmd = decode_pkg::CMD_ROR;
                    default:              alu_cmd = decode_pkg::CMD_SRL;
                endcase
            end
            // Address is rs plus the sign-extended offset
            decode_pkg::OP_ST: begin
                mem_write = 1'b1;
                alu_src_b = decode_pkg::SRC_B_IMM;
            end
            decode_pkg::OP_LD: begin
                mem_read   = 1'b1;
                alu_src_b  = decode_pkg::SRC_B_IMM;
                reg_write  = 1'b1;
                dst_sel    = decode_pkg::DST_RT;
                mem_to_reg = decode_pkg::WB_MEM;
            end
            decode_pkg::OP_LBI: begin
                reg_write = 1'b1;
                imm_sel   = decode_pkg::IMM_SEXT8;
                alu_src_a = decode_pkg::SRC_A_ZERO;
                alu_src_b = decode_pkg::SRC_B_IMM;
            end
            decode_pkg::OP_SLBI: begin
                reg_write = 1'b1;
                imm_sel   = decode_pkg::IMM_ZEXT8;
                alu_src_a = decode_pkg::SRC_A_RS_SHL8;
                alu_src_b = decode_pkg::SRC_B_IMM;
                alu_cmd   = decode_pkg::CMD_OR;
            end
            decode_pkg::OP_ARITH, decode_pkg::OP_SHIFT: begin
                reg_write = 1'b1;
                dst_sel   = decode_pkg::DST_RD;
                alu_cmd   = (opcode == decode_pkg::OP_ARITH) ? decode_pkg::CMD_RR_ARITH
                                                             : decode_pkg::CMD_RR_SHIFT;
            end
            decode_pkg::OP_SEQ, decode_pkg::OP_SLT, decode_pkg::OP_SLE: begin
                reg_write   = 1'b1;
                dst_sel     = decode_pkg::DST_RD;
                alu_cmd     = decode_pkg::CMD_CMP;
                sign_alu    = 1'b1;
                alu_res_sel = 1'b1;
                mem_to_reg  = decode_pkg::WB_SET;
                case (opcode)
                    decode_pkg::OP_SEQ: set_select = decode_pkg::SET_EQ;
                    decode_pkg::OP_SLT: set_select = decode_pkg::SET_LT;
                    default:            set_select = decode_pkg::SET_LE;
                endcase
            end
            decode_pkg::OP_BEQZ, decode_pkg::OP_BNEZ,
            decode_pkg::OP_BLTZ, decode_pkg::OP_BGEZ: begin
                branch    = 1'b1;
                pc_dec    = decode_pkg::PC_BRANCH;
                imm_sel   = decode_pkg::IMM_SEXT8;
                alu_src_b = decode_pkg::SRC_B_ZERO;
                // BNEZ is flagged as eqz and ltz together
                branch_eqz = (opcode == decode_pkg::OP_BEQZ) || (opcode == decode_pkg::OP_BNEZ);
                branch_ltz = (opcode == decode_pkg::OP_BLTZ) || (opcode == decode_pkg::OP_BNEZ);
                branch_gtz = (opcode == decode_pkg::OP_BGEZ);
            end
            decode_pkg::OP_J: pc_dec = decode_pkg::PC_JUMP;
            decode_pkg::OP_JAL: begin
                pc_dec     = decode_pkg::PC_JUMP;
                reg_write  = 1'b1;
                dst_sel    = decode_pkg::DST_R7;
                mem_to_reg = decode_pkg::WB_PC2;
            end
            default: control_err = 1'b1;
        endcase
    end

    assign createdump = 1'b0;

    always_comb begin
        a_mem_excl: assert final (!(mem_read && mem_write))
            else $error("mem_read and mem_write both high");
        a_err_no_write: assert final (!(reg_write && control_err))
            else $error("reg_write high on an illegal opcode");
    end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire         clk,
    input  wire         rst_n,
    input  wire  [2:0]  read1_sel,
    input  wire  [2:0]  read2_sel,
    input  wire  [2:0]  write_sel,
    input  wire  [15:0] write_data,
    input  wire         write,
    output logic [15:0] read1_data,
    output logic [15:0] read2_data
);

    logic [15:0] regs [8];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= 16'h0000;
            end
        end else if (write) begin
            regs[write_sel] <= write_data;
        end
    end

    // No bypass, a write shows up on the reads after the edge
    assign read1_data = regs[read1_sel];
    assign read2_data = regs[read2_sel];

    a_write_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(write)
    ) else $error("reg_file write enable is unknown");

endmodule

`default_nettype wire

// ==== vlog.f ====
decode_pkg.sv
reg_file.sv
main_control.sv
alu_control.sv
decode.sv
decode_checker.sv
decode_tb.sv
